// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := sdmac_tb
FILELIST := sdmac.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: include/sdmac_defs.svh
/*
 Build-time constants for the sdmac core: port count, I/O wait length,
 register and port address map, and the CNTR write mask.
*/
`ifndef SDMAC_DEFS_SVH
`define SDMAC_DEFS_SVH

// Peripheral port sequencers, css_n / csx0_n / csx1_n
`define SDMAC_N_PORTS 3

// Minimum strobe low time in sclk cycles
`define SDMAC_IO_WAIT 3

// Word addresses on CPU A6..A2
`define SDMAC_CNTR_ADDR 5'h02
`define SDMAC_ISTR_ADDR 5'h07

// Port windows, port k starts at BASE + k * SPAN
`define SDMAC_PORT_BASE 5'h10
`define SDMAC_PORT_SPAN 4

// Writable CNTR bits
`define SDMAC_CNTR_MASK 32'h0000_001F

// Interrupt enable inside CNTR
`define SDMAC_INTEN_BIT 2

`endif

// File: sdmac.f
+incdir+include
src/sdmac_pkg.sv
src/sdmac_addr_decoder.sv
src/sdmac_regs.sv
src/sdmac_port_cycle.sv
src/sdmac_bus_return.sv
src/sdmac_top.sv
sim/sdmac_tb.sv

// File: sim/sdmac_tb.sv
/*
 Testbench for the sdmac core. Drives register, interrupt and port accesses
 against a behavioral peripheral, and assertions check every response.
*/
`timescale 1ns/1ps
`default_nettype none
`include "sdmac_defs.svh"

module sdmac_tb;

    localparam logic [31:0] SEED        = 32'hc2e1d782;
    localparam int          ACK_TIMEOUT = 64;         // Negedges allowed for dsack_n
    localparam int          INT_TIMEOUT = 32;
    localparam int          REG_LAT     = 1 + 2 + 1;  // Negedges from the drive edge to dsack_n
    localparam int          INT_LAT     = 1 + 3;      // Negedges from the drive edge to int_n

    logic        sclk;
    logic        arst_n;
    logic        cs_n;
    logic        as_n;
    logic        ds_n;
    logic        r_w;
    logic [4:0]  addr;
    logic        a12;
    logic [31:0] data_in;
    logic        inta;
    logic        intb;
    logic        iordy;
    logic [15:0] pd_in;
    logic [31:0] data_out;
    logic        data_oe;
    logic [1:0]  dsack_n;
    logic        siz1;
    logic        int_n;
    logic        ior_n;
    logic        iow_n;
    logic        css_n;
    logic        csx0_n;
    logic        csx1_n;
    logic [15:0] pd_out;
    logic        pd_oe;

    logic [31:0] main_lfsr;      // CPU side stimulus
    logic [31:0] periph_lfsr;    // Peripheral model stream
    logic        exp_rd;         // Direction of the access in flight
    logic [2:0]  exp_cs;         // {csx1, csx0, css} allowed low
    logic [15:0] exp_wdata;
    logic [15:0] pd_expect;      // Last word the peripheral drove
    logic        io_low;         // Strobe seen at negedge
    logic        io_active;
    int          stall_left;
    int          low_cycles;
    int          val_errors;
    int          prop_errors;
    int          timeouts;
    logic        timed_out;

    sdmac_top sdmac_top_inst (.*);

    always #4 sclk = ~sclk;      // 8 ns period

    // One Galois LFSR step
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_next(state);
            bits  = {bits[30:0], state[0]};
        end
    endtask

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        val_errors++;
        $display("FAIL %0d ns %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic protocol_error(input string msg);
        prop_errors++;
        $display("Error at %0d ns: %s", $time, msg);
    endtask

    task automatic report_timeout(input string msg);
        timeouts++;
        timed_out = 1'b1;
        $display("Timeout at %0d ns: %s", $time, msg);
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else value_error(name, got, exp);
    endtask

    // ISTR word built from the register layout
    function automatic logic [31:0] istr_expect(input logic inten, input logic a, input logic b);
        logic [31:0] w;
        w    = '0;
        w[4] = inten && (a || b);    // INT_P
        w[3] = a;                    // INTS_A
        w[2] = b;                    // INTS_B
        return w;
    endfunction

    // Protocol checks
    assert property (@(posedge sclk) disable iff (!arst_n)
        (!as_n && dsack_n != 2'b11) |=> $stable(dsack_n))
        else protocol_error("dsack_n changed while as_n was low");
    assert property (@(posedge sclk) disable iff (!arst_n) as_n |=> dsack_n == 2'b11)
        else protocol_error("dsack_n not released after as_n rose");
    assert property (@(posedge sclk) disable iff (!arst_n) (!ior_n || !iow_n) |-> dsack_n == 2'b11)
        else protocol_error("dsack_n fell while a port strobe was still low");
    assert property (@(posedge sclk) disable iff (!arst_n) (!ior_n && !iordy) |=> !ior_n)
        else protocol_error("ior_n rose while iordy was low");
    assert property (@(posedge sclk) disable iff (!arst_n) (!iow_n && !iordy) |=> !iow_n)
        else protocol_error("iow_n rose while iordy was low");
    assert property (@(posedge sclk) disable iff (!arst_n)
        (~{csx1_n, csx0_n, css_n} & ~exp_cs) == 3'b000)
        else protocol_error("wrong chip select went low");
    assert property (@(posedge sclk) disable iff (!arst_n) !ior_n |-> exp_rd)
        else protocol_error("ior_n low during a write");
    assert property (@(posedge sclk) disable iff (!arst_n) !iow_n |-> !exp_rd)
        else protocol_error("iow_n low during a read");
    assert property (@(posedge sclk) disable iff (!arst_n) pd_oe |-> pd_out == exp_wdata)
        else value_error("pd_out", 32'($sampled(pd_out)), 32'(exp_wdata));

    // Strobe width counted in negedges
    always @(negedge sclk) begin
        io_low = !ior_n || !iow_n;
        if (io_low) begin
            low_cycles = low_cycles + 1;
        end else if (low_cycles != 0) begin
            assert (low_cycles >= `SDMAC_IO_WAIT)
                else protocol_error($sformatf("strobe low for only %0d cycles", low_cycles));
            low_cycles = 0;
        end
    end

    // Peripheral model draws new data and a 0 to 5 cycle iordy stall per strobe
    always @(posedge sclk) begin
        logic [31:0] rv;
        int          stall;
        if (!io_active && io_low) begin
            draw_bits(periph_lfsr, 16, rv);
            pd_in     <= rv[15:0];
            pd_expect <= rv[15:0];
            draw_bits(periph_lfsr, 3, rv);
            stall      = int'(rv[2:0]) % 6;
            stall_left <= stall;
            iordy      <= (stall == 0);
            io_active  <= 1'b1;
        end else if (io_active) begin
            if (stall_left <= 1) begin
                iordy <= 1'b1;
            end
            if (stall_left > 0) begin
                stall_left <= stall_left - 1;
            end
            if (!io_low) begin
                io_active <= 1'b0;        // Strobe over
            end
        end
    end

    task automatic check_reset_state();
        expect_eq("dsack_n", dsack_n, 2'b11);
        expect_eq("int_n", int_n, 1'b1);
        expect_eq("ior_n", ior_n, 1'b1);
        expect_eq("iow_n", iow_n, 1'b1);
        expect_eq("{csx1_n, csx0_n, css_n}", {csx1_n, csx0_n, css_n}, 3'b111);
        expect_eq("data_oe", data_oe, 1'b0);
        expect_eq("pd_oe", pd_oe, 1'b0);
        expect_eq("siz1", siz1, 1'b0);
    endtask

    // One CPU access where port < 0 selects a register
    task automatic cpu_cycle(input logic rd, input logic [4:0] a, input logic [31:0] wd,
                             input int port, output logic [31:0] rdata);
        int         lat;
        logic [2:0] cs_seen;
        logic       strobe_seen;
        logic       oe_seen;
        rdata       = '0;
        lat         = 0;
        cs_seen     = '0;
        strobe_seen = 1'b0;
        oe_seen     = 1'b0;
        if (timed_out) return;
        exp_rd    = rd;
        exp_wdata = wd[15:0];
        exp_cs    = (port < 0) ? 3'b000 : 3'(1 << port);
        @(posedge sclk);
        cs_n    <= 1'b0;
        as_n    <= 1'b0;
        ds_n    <= 1'b0;
        r_w     <= rd;
        addr    <= a;
        data_in <= wd;
        do begin
            @(negedge sclk);
            lat++;
            cs_seen     = cs_seen | ~{csx1_n, csx0_n, css_n};
            strobe_seen = strobe_seen | (rd ? !ior_n : !iow_n);
            oe_seen     = oe_seen | pd_oe;
        end while (dsack_n == 2'b11 && lat < ACK_TIMEOUT);
        if (dsack_n == 2'b11) begin
            report_timeout("dsack_n never asserted");
            return;
        end
        if (port < 0) begin
            expect_eq("dsack_n", dsack_n, 2'b00);
            expect_eq("siz1", siz1, 1'b0);
            assert (lat == REG_LAT)
                else protocol_error($sformatf("register dsack_n after %0d cycles", lat));
        end else begin
            expect_eq("dsack_n", dsack_n, 2'b01);
            expect_eq("siz1", siz1, 1'b1);
            expect_eq("{csx1_n, csx0_n, css_n} low", cs_seen, exp_cs);
            expect_eq("pd_oe during access", oe_seen, !rd);
            assert (strobe_seen) else protocol_error("port strobe never went low");
            if (rd) begin
                expect_eq("data_out", data_out, {pd_expect, pd_expect});
            end
        end
        expect_eq("data_oe", data_oe, rd);
        rdata = data_out;
        repeat (2) @(negedge sclk);                         // CPU still holds as_n
        expect_eq("dsack_n", dsack_n, (port < 0) ? 2'b00 : 2'b01);
        @(posedge sclk);
        cs_n <= 1'b1;
        as_n <= 1'b1;
        ds_n <= 1'b1;
        lat = 0;
        do begin
            @(negedge sclk);
            lat++;
        end while (dsack_n != 2'b11 && lat < ACK_TIMEOUT);
        if (dsack_n != 2'b11) begin
            report_timeout("dsack_n stuck low after as_n rose");
        end else begin
            expect_eq("data_oe", data_oe, 1'b0);
        end
    endtask

    task automatic port_access(input logic rd, input int k);
        logic [31:0] wd;
        logic [31:0] off;
        logic [31:0] rd_val;
        draw_bits(main_lfsr, 32, wd);
        draw_bits(main_lfsr, 2, off);                       // Any word in the window
        cpu_cycle(rd, 5'(`SDMAC_PORT_BASE + k * `SDMAC_PORT_SPAN + off), wd, k, rd_val);
    endtask

    task automatic check_int_path(input logic inten, input logic a, input logic b);
        int          lat;
        logic [31:0] rd_val;
        lat = 0;
        if (timed_out) return;
        cpu_cycle(1'b0, `SDMAC_CNTR_ADDR, 32'(inten) << `SDMAC_INTEN_BIT, -1, rd_val);
        @(posedge sclk);
        inta <= a;
        intb <= b;
        if (inten) begin
            do begin
                @(negedge sclk);
                lat++;
            end while (int_n && lat < INT_TIMEOUT);
            if (int_n) begin
                report_timeout("int_n never asserted");
                return;
            end
            assert (lat <= INT_LAT)
                else protocol_error($sformatf("int_n asserted after %0d cycles", lat));
        end else begin
            for (int i = 0; i < 8; i++) begin              // Must stay high while disabled
                @(negedge sclk);
                expect_eq("int_n", int_n, 1'b1);
            end
        end
        cpu_cycle(1'b1, `SDMAC_ISTR_ADDR, '0, -1, rd_val);
        expect_eq("ISTR", rd_val, istr_expect(inten, a, b));
        @(posedge sclk);
        inta <= 1'b0;
        intb <= 1'b0;
        lat = 0;
        do begin
            @(negedge sclk);
            lat++;
        end while (!int_n && lat < INT_TIMEOUT);
        if (!int_n) report_timeout("int_n stuck low after inputs cleared");
    endtask

    initial begin
        logic [31:0] wd;
        logic [31:0] rd_val;
        sclk        = 1'b0;
        arst_n      = 1'b0;
        cs_n        = 1'b1;
        as_n        = 1'b1;
        ds_n        = 1'b1;
        r_w         = 1'b1;
        addr        = '0;
        a12         = 1'b0;
        data_in     = '0;
        inta        = 1'b0;
        intb        = 1'b0;
        iordy       = 1'b1;
        pd_in       = '0;
        main_lfsr   = SEED;
        periph_lfsr = SEED;
        exp_rd      = 1'b0;
        exp_cs      = '0;
        exp_wdata   = '0;
        pd_expect   = '0;
        io_low      = 1'b0;
        io_active   = 1'b0;
        stall_left  = 0;
        low_cycles  = 0;
        val_errors  = 0;
        prop_errors = 0;
        timeouts    = 0;
        timed_out   = 1'b0;

        repeat (9) @(posedge sclk);
        @(negedge sclk);
        check_reset_state();
        @(posedge sclk);
        arst_n <= 1'b1;                                     // 10 cycles in reset
        @(negedge sclk);
        check_reset_state();

        // CNTR write and readback through the mask
        for (int i = 0; i < 4; i++) begin
            draw_bits(main_lfsr, 32, wd);
            cpu_cycle(1'b0, `SDMAC_CNTR_ADDR, wd, -1, rd_val);
            cpu_cycle(1'b1, `SDMAC_CNTR_ADDR, '0, -1, rd_val);
            expect_eq("CNTR", rd_val, wd & `SDMAC_CNTR_MASK);
        end
        cpu_cycle(1'b1, `SDMAC_ISTR_ADDR, '0, -1, rd_val);
        expect_eq("ISTR", rd_val, istr_expect(wd[`SDMAC_INTEN_BIT], 1'b0, 1'b0));

        check_int_path(1'b1, 1'b1, 1'b0);
        check_int_path(1'b1, 1'b0, 1'b1);
        check_int_path(1'b1, 1'b1, 1'b1);
        check_int_path(1'b0, 1'b1, 1'b1);
        check_int_path(1'b0, 1'b1, 1'b0);

        // Writes and reads on each chip select
        for (int rep = 0; rep < 4; rep++) begin
            for (int k = 0; k < `SDMAC_N_PORTS; k++) begin
                port_access(1'b0, k);
                port_access(1'b1, k);
            end
        end

        repeat (2) @(negedge sclk);
        $display("Errors: %0d value, %0d protocol, %0d timeout",
                 val_errors, prop_errors, timeouts);
        if (val_errors + prop_errors + timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/sdmac_addr_decoder.sv
/*
 CPU address decoder. Turns a qualified access into one start pulse for a
 register or a peripheral port and stays busy until as_n goes high.
*/
`timescale 1ns/1ps
`default_nettype none
`include "sdmac_defs.svh"

module sdmac_addr_decoder (
    input  logic                      sclk,
    input  logic                      arst_n,
    input  logic                      cs_n,        // SCSI select from the bus controller
    input  logic                      as_n,
    input  logic                      ds_n,
    input  logic                      r_w,         // 1 is read
    input  logic                      a12,         // Must be low, leaves room for IDE
    input  logic [4:0]                addr,        // CPU A6..A2
    output logic                      reg_start,
    output sdmac_pkg::reg_id_t        reg_id,
    output logic [`SDMAC_N_PORTS-1:0] port_start,
    output logic                      port_rd      // Direction held for the whole access
);
    import sdmac_pkg::*;

    logic                      busy;        // Access in flight, blocks new starts
    logic                      sel;
    logic                      hit;         // Address maps to something
    reg_id_t                   hit_id;
    logic [`SDMAC_N_PORTS-1:0] hit_port;
    logic [4:0]                win_off;     // Offset into the port windows

    assign sel     = !cs_n && !as_n && !ds_n && !a12 && !busy;
    assign win_off = addr - `SDMAC_PORT_BASE;
    assign hit     = (hit_id != REG_NONE) || (|hit_port);

    always_comb begin
        hit_id = REG_NONE;
        if (addr == `SDMAC_CNTR_ADDR) begin
            hit_id = REG_CNTR;
        end else if (addr == `SDMAC_ISTR_ADDR) begin
            hit_id = REG_ISTR;
        end
    end

    // One window of SPAN words per port, rest of the range unmapped
    always_comb begin
        for (int k = 0; k < `SDMAC_N_PORTS; k++) begin
            hit_port[k] = (addr >= `SDMAC_PORT_BASE) &&
                          ((32'(win_off) / `SDMAC_PORT_SPAN) == k);
        end
    end

    always_ff @(posedge sclk or negedge arst_n) begin
        if (!arst_n) begin
            busy       <= 1'b0;
            reg_start  <= 1'b0;
            reg_id     <= REG_NONE;
            port_start <= '0;
            port_rd    <= 1'b0;
        end else begin
            reg_start  <= sel && (hit_id != REG_NONE);  // Single cycle pulses
            reg_id     <= sel ? hit_id : REG_NONE;
            port_start <= sel ? hit_port : '0;
            if (sel) begin
                port_rd <= r_w;
            end
            if (sel && hit) begin
                busy <= 1'b1;
            end else if (as_n) begin
                busy <= 1'b0;                           // CPU ended the cycle
            end
        end
    end

endmodule

`default_nettype wire

// File: src/sdmac_bus_return.sv
/*
 Merges the peripheral port strobes and data onto the shared pins and ends
 each CPU access with dsack_n and siz1 until as_n is released.
*/
`timescale 1ns/1ps
`default_nettype none
`include "sdmac_defs.svh"

module sdmac_bus_return (
    input  logic                      sclk,
    input  logic                      arst_n,
    input  logic                      as_n,
    input  logic                      port_rd,
    input  logic                      reg_done,
    input  sdmac_pkg::cpu_word_t      reg_rdata,
    input  logic [`SDMAC_N_PORTS-1:0] port_done,
    input  sdmac_pkg::pd_word_t       port_rdata [`SDMAC_N_PORTS],
    input  logic [`SDMAC_N_PORTS-1:0] port_rd_n,
    input  logic [`SDMAC_N_PORTS-1:0] port_wr_n,
    input  logic [`SDMAC_N_PORTS-1:0] port_oe,
    input  sdmac_pkg::pd_word_t       port_pdout [`SDMAC_N_PORTS],
    output logic                      ior_n,
    output logic                      iow_n,
    output logic                      pd_oe,
    output sdmac_pkg::pd_word_t       pd_out,
    output sdmac_pkg::cpu_word_t      data_out,
    output logic                      data_oe,
    output logic [1:0]                dsack_n,    // 00 is 32 bit, 01 is 16 bit
    output logic                      siz1
);
    import sdmac_pkg::*;

    pd_word_t done_word;      // Read data of the finishing port
    logic     port_end;

    assign ior_n    = &port_rd_n;     // Shared active low strobes
    assign iow_n    = &port_wr_n;
    assign pd_oe    = |port_oe;
    assign port_end = |port_done;

    // AND-OR select, only one port is active at a time
    always_comb begin
        pd_out    = '0;
        done_word = '0;
        for (int k = 0; k < `SDMAC_N_PORTS; k++) begin
            if (port_oe[k]) begin
                pd_out = pd_out | port_pdout[k];
            end
            if (port_done[k]) begin
                done_word = done_word | port_rdata[k];
            end
        end
    end

    always_ff @(posedge sclk or negedge arst_n) begin
        if (!arst_n) begin
            dsack_n <= 2'b11;
            siz1    <= 1'b0;
            data_oe <= 1'b0;
        end else if (as_n) begin
            dsack_n <= 2'b11;       // Cycle over
            siz1    <= 1'b0;
            data_oe <= 1'b0;
        end else if (reg_done) begin
            dsack_n <= 2'b00;
            siz1    <= 1'b0;
            data_oe <= port_rd;
        end else if (port_end) begin
            dsack_n <= 2'b01;       // 16 bit port
            siz1    <= 1'b1;
            data_oe <= port_rd;
        end
    end

    always_ff @(posedge sclk) begin
        if (reg_done) begin
            data_out <= reg_rdata;
        end else if (port_end) begin
            data_out <= {done_word, done_word};     // Both halves for 16 bit
        end
    end

endmodule

`default_nettype wire

// File: src/sdmac_pkg.sv
/*
 Shared data and register-identifier types for the sdmac core.
 Modules name these types with scoped names or a wildcard import.
*/
`default_nettype none

package sdmac_pkg;

    // CPU side data word
    typedef logic [31:0] cpu_word_t;

    // Peripheral port data word
    typedef logic [15:0] pd_word_t;

    // Internal register selected by the address decoder
    typedef enum logic [1:0] {
        REG_CNTR,     // Control register
        REG_ISTR,     // Interrupt status, read only
        REG_NONE      // No register access this cycle
    } reg_id_t;

endpackage

`default_nettype wire

// File: src/sdmac_port_cycle.sv
/*
 Strobe sequencer for one peripheral chip select. Holds the strobe for the
 minimum wait, stretches it on iordy low and captures read data at its end.
*/
`timescale 1ns/1ps
`default_nettype none
`include "sdmac_defs.svh"

module sdmac_port_cycle (
    input  logic                sclk,
    input  logic                arst_n,
    input  logic                start,       // One cycle pulse from the decoder
    input  logic                rd,          // 1 is a read cycle
    input  sdmac_pkg::pd_word_t wdata,
    input  logic                iordy,       // Low stretches the strobe
    input  sdmac_pkg::pd_word_t pd_in,
    output logic                cs_n,
    output logic                rd_n,
    output logic                wr_n,
    output logic                pd_oe,
    output sdmac_pkg::pd_word_t pd_out,
    output sdmac_pkg::pd_word_t rdata,
    output logic                done
);

    localparam int                CNT_W     = $clog2(`SDMAC_IO_WAIT + 1);
    localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(`SDMAC_IO_WAIT - 1);

    typedef enum logic [1:0] {
        IDLE,
        STROBE,     // rd_n or wr_n low
        RELEASE     // Strobe up, cs_n still low
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] wait_cnt;
    logic             wait_met;
    logic             strobe_end;

    assign wait_met   = (wait_cnt == WAIT_LAST);
    assign strobe_end = (state == STROBE) && wait_met && iordy;

    always_ff @(posedge sclk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            wait_cnt <= '0;
            cs_n     <= 1'b1;
            rd_n     <= 1'b1;
            wr_n     <= 1'b1;
            pd_oe    <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state    <= STROBE;
                        wait_cnt <= '0;
                        cs_n     <= 1'b0;
                        rd_n     <= !rd;
                        wr_n     <= rd;
                        pd_oe    <= !rd;    // Drive the port on writes only
                    end
                end
                STROBE: begin
                    if (strobe_end) begin
                        state <= RELEASE;
                        rd_n  <= 1'b1;
                        wr_n  <= 1'b1;
                        done  <= 1'b1;
                    end else if (!wait_met) begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                RELEASE: begin
                    state <= IDLE;
                    cs_n  <= 1'b1;
                    pd_oe <= 1'b0;          // Write data held past the strobe edge
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge sclk) begin
        if ((state == IDLE) && start) begin
            pd_out <= wdata;
        end
        if (strobe_end && !rd_n) begin
            rdata <= pd_in;                 // Sampled as ior_n rises
        end
    end

endmodule

`default_nettype wire

// File: src/sdmac_regs.sv
/*
 CNTR and ISTR registers. Syncs the two interrupt inputs, builds the
 pending flag and drives int_n; answers each register start with reg_done.
*/
`timescale 1ns/1ps
`default_nettype none
`include "sdmac_defs.svh"

module sdmac_regs (
    input  logic                 sclk,
    input  logic                 arst_n,
    input  logic                 reg_start,
    input  sdmac_pkg::reg_id_t   reg_id,
    input  logic                 r_w,
    input  sdmac_pkg::cpu_word_t data_in,
    input  logic                 inta,        // From the SCSI controller, async
    input  logic                 intb,        // Spare interrupt, async
    output sdmac_pkg::cpu_word_t rd_data,
    output logic                 reg_done,
    output logic                 int_n        // Level interrupt to the CPU
);
    import sdmac_pkg::*;

    localparam int INT_P_BIT  = 4;
    localparam int INTS_A_BIT = 3;
    localparam int INTS_B_BIT = 2;

    cpu_word_t  cntr;
    cpu_word_t  istr;
    logic [1:0] int_meta;     // First sync stage, {a, b}
    logic [1:0] int_sync;     // Second sync stage
    logic       int_p;        // Enabled and pending

    // Two flop synchronizer for inta and intb
    always_ff @(posedge sclk or negedge arst_n) begin
        if (!arst_n) begin
            int_meta <= '0;
            int_sync <= '0;
        end else begin
            int_meta <= {inta, intb};
            int_sync <= int_meta;
        end
    end

    assign int_p = cntr[`SDMAC_INTEN_BIT] && (|int_sync);

    // Status word, unused bits read as zero
    always_comb begin
        istr             = '0;
        istr[INT_P_BIT]  = int_p;
        istr[INTS_A_BIT] = int_sync[1];
        istr[INTS_B_BIT] = int_sync[0];
    end

    always_ff @(posedge sclk or negedge arst_n) begin
        if (!arst_n) begin
            cntr     <= '0;
            reg_done <= 1'b0;
            int_n    <= 1'b1;
        end else begin
            reg_done <= reg_start;      // Access finishes one edge later
            int_n    <= !int_p;
            if (reg_start && !r_w && (reg_id == REG_CNTR)) begin
                cntr <= data_in & `SDMAC_CNTR_MASK;
            end
            // ISTR writes are ignored
        end
    end

    // Read data latched on the start edge
    always_ff @(posedge sclk) begin
        if (reg_start && r_w) begin
            case (reg_id)
                REG_CNTR: rd_data <= cntr;
                REG_ISTR: rd_data <= istr;
                default:  rd_data <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/sdmac_top.sv
/*
 Top level of the sdmac CPU slave core. Connects the decoder, the register
 block, one sequencer per chip select and the bus return logic.
*/
`timescale 1ns/1ps
`default_nettype none
`include "sdmac_defs.svh"

module sdmac_top (
    input  logic                 sclk,
    input  logic                 arst_n,
    input  logic                 cs_n,
    input  logic                 as_n,
    input  logic                 ds_n,
    input  logic                 r_w,
    input  logic [4:0]           addr,
    input  logic                 a12,
    input  sdmac_pkg::cpu_word_t data_in,
    input  logic                 inta,
    input  logic                 intb,
    input  logic                 iordy,
    input  sdmac_pkg::pd_word_t  pd_in,
    output sdmac_pkg::cpu_word_t data_out,
    output logic                 data_oe,
    output logic [1:0]           dsack_n,
    output logic                 siz1,
    output logic                 int_n,
    output logic                 ior_n,
    output logic                 iow_n,
    output logic                 css_n,       // Port 0, SCSI controller
    output logic                 csx0_n,      // Port 1
    output logic                 csx1_n,      // Port 2
    output sdmac_pkg::pd_word_t  pd_out,
    output logic                 pd_oe
);
    import sdmac_pkg::*;

    logic                      reg_start;
    reg_id_t                   reg_id;
    logic                      reg_done;
    cpu_word_t                 reg_rdata;
    logic [`SDMAC_N_PORTS-1:0] port_start;
    logic                      port_rd;
    logic [`SDMAC_N_PORTS-1:0] port_cs_n;
    logic [`SDMAC_N_PORTS-1:0] port_rd_n;
    logic [`SDMAC_N_PORTS-1:0] port_wr_n;
    logic [`SDMAC_N_PORTS-1:0] port_oe;
    logic [`SDMAC_N_PORTS-1:0] port_done;
    pd_word_t                  port_pdout [`SDMAC_N_PORTS];
    pd_word_t                  port_rdata [`SDMAC_N_PORTS];

    sdmac_addr_decoder decoder_inst (
        .sclk       (sclk),
        .arst_n     (arst_n),
        .cs_n       (cs_n),
        .as_n       (as_n),
        .ds_n       (ds_n),
        .r_w        (r_w),
        .a12        (a12),
        .addr       (addr),
        .reg_start  (reg_start),
        .reg_id     (reg_id),
        .port_start (port_start),
        .port_rd    (port_rd)
    );

    sdmac_regs regs_inst (
        .sclk      (sclk),
        .arst_n    (arst_n),
        .reg_start (reg_start),
        .reg_id    (reg_id),
        .r_w       (r_w),
        .data_in   (data_in),
        .inta      (inta),
        .intb      (intb),
        .rd_data   (reg_rdata),
        .reg_done  (reg_done),
        .int_n     (int_n)
    );

    for (genvar k = 0; k < `SDMAC_N_PORTS; k++) begin : g_port
        sdmac_port_cycle port_inst (
            .sclk   (sclk),
            .arst_n (arst_n),
            .start  (port_start[k]),
            .rd     (port_rd),
            .wdata  (data_in[15:0]),    // Low half carries port write data
            .iordy  (iordy),
            .pd_in  (pd_in),
            .cs_n   (port_cs_n[k]),
            .rd_n   (port_rd_n[k]),
            .wr_n   (port_wr_n[k]),
            .pd_oe  (port_oe[k]),
            .pd_out (port_pdout[k]),
            .rdata  (port_rdata[k]),
            .done   (port_done[k])
        );
    end

    sdmac_bus_return bus_return_inst (
        .sclk       (sclk),
        .arst_n     (arst_n),
        .as_n       (as_n),
        .port_rd    (port_rd),
        .reg_done   (reg_done),
        .reg_rdata  (reg_rdata),
        .port_done  (port_done),
        .port_rdata (port_rdata),
        .port_rd_n  (port_rd_n),
        .port_wr_n  (port_wr_n),
        .port_oe    (port_oe),
        .port_pdout (port_pdout),
        .ior_n      (ior_n),
        .iow_n      (iow_n),
        .pd_oe      (pd_oe),
        .pd_out     (pd_out),
        .data_out   (data_out),
        .data_oe    (data_oe),
        .dsack_n    (dsack_n),
        .siz1       (siz1)
    );

    assign css_n  = port_cs_n[0];
    assign csx0_n = port_cs_n[1];
    assign csx1_n = port_cs_n[2];

endmodule

`default_nettype wire
